// File: build.f
hdl/mxv_pkg.sv
hdl/mxv_load.sv
hdl/mxv_sequencer.sv
hdl/mxv_pe_array.sv
hdl/mxv_result_store.sv
hdl/mxv_top.sv
testbench/tb_mxv.sv

// File: run.sh
#!/bin/sh
# compile and run tb_mxv with Verilator, exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mxv -Mdir obj_dir -f build.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile step returned status $status"
	exit $status
fi

./obj_dir/Vtb_mxv
status=$?
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit $status
fi

exit 0

// File: testbench/tb_mxv.sv
`timescale 1ns/1ps

module tb_mxv
	import mxv_pkg::*;
();

	localparam int IN_CREDITS  = 4;
	localparam int OUT_CREDITS = 2;

	logic      clk = 1'b0;
	logic      reset;
	logic      in_valid;
	in_beat_t  in_beat;
	logic      in_credit;
	logic      out_valid;
	res_beat_t out_beat;
	logic      out_credit;

	logic [31:0] rng;	// xorshift state
	res_beat_t   exp_q [$];	// expected beats, every job in send order
	string       exp_name [$];	// test that owns each beat
	int          exp_count   = 0;
	int          rd_idx      = 0;	// beats seen at the outputs
	int          credits_got = 0;	// in_credit pulses seen
	int          words_sent  = 0;
	int          credits_back = 0;	// out_credit pulses given
	int          hold_left   = 0;	// sink withholds credits while nonzero
	int          cycles      = 0;
	int          limit       = 48;	// reset and credit start-up

	mxv_top #(.IN_CREDITS(IN_CREDITS), .OUT_CREDITS(OUT_CREDITS)) u_mxv_top (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_beat(in_beat), .in_credit(in_credit),
		.out_valid(out_valid), .out_beat(out_beat), .out_credit(out_credit)
	);

	always #2 clk = ~clk;	// 4 ns period

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	task automatic stop_with(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int draw(input int span);
		rng = xorshift32(rng);
		return int'(rng % 32'(span));
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;	// drive just after the edge
	endtask

	// waits for a credit, sends one word, then idles gap cycles
	task automatic send_word(input in_beat_t w, input int gap);
		while (credits_got <= words_sent) begin
			in_valid = 1'b0;
			next_cycle();
		end
		in_valid   = 1'b1;
		in_beat    = w;
		words_sent = words_sent + 1;
		next_cycle();
		in_valid = 1'b0;
		repeat (gap) next_cycle();
	endtask

	// builds one job, queues its expected rows, streams it in
	task automatic send_job(input string name, input int n, input int gap, input bit max_val);
		elem_t     mat [MAX_N][MAX_N];
		elem_t     vec [MAX_N];
		int        sum;
		res_beat_t b;
		in_beat_t  w;
		for (int r = 0; r < n; r++)
			for (int c = 0; c < n; c++)
				mat[r][c] = max_val ? 8'hff : elem_t'(draw(256));
		for (int c = 0; c < n; c++)
			vec[c] = max_val ? 8'hff : elem_t'(draw(256));
		for (int r = 0; r < n; r++) begin	// row r = sum of mat(r,j) * vec(j)
			sum = 0;
			for (int c = 0; c < n; c++)
				sum = sum + int'(mat[r][c]) * int'(vec[c]);
			b.row   = ROW_W'(r);
			b.value = ACC_W'(sum);
			b.last  = (r == n - 1);
			exp_q.push_back(b);
			exp_name.push_back(name);
			exp_count = exp_count + 1;
		end
		limit = limit + 4 * (n * n + n + 20) + (n * n + n + 1) * gap;
		w = '0;
		w.word.hdr.kind = 1'b1;	// header first
		w.word.hdr.n    = N_W'(n);
		send_word(w, gap);
		for (int r = 0; r < n; r++)
			for (int c = 0; c < n; c++) begin
				w = '0;
				w.word.data.elem = mat[r][c];	// row-major
				send_word(w, gap);
			end
		for (int c = 0; c < n; c++) begin
			w = '0;
			w.word.data.elem = vec[c];
			send_word(w, gap);
		end
	endtask

	task automatic wait_drain();
		while (rd_idx < exp_count)
			next_cycle();
	endtask

	////////////////////////////////////////
	// port monitors, sink and timeout
	////////////////////////////////////////
	always @(posedge clk) begin
		if (!reset) begin
			if (in_credit)
				credits_got <= credits_got + 1;
			if (out_valid)
				rd_idx <= rd_idx + 1;	// head moves at the end of the beat
		end
	end

	// one credit back per beat taken, except during a hold
	initial begin
		out_credit = 1'b0;
		forever begin
			next_cycle();
			if (hold_left > 0) begin
				hold_left  = hold_left - 1;
				out_credit = 1'b0;
			end else if (!reset && credits_back < rd_idx) begin
				out_credit   = 1'b1;
				credits_back = credits_back + 1;
			end else begin
				out_credit = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit)
			stop_with($sformatf("timeout after %0d cycles with %0d of %0d results seen",
				cycles, rd_idx, exp_count));
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////
	a_beat_owed: assert property (@(negedge clk) disable iff (reset)
		out_valid |-> (rd_idx < exp_count))
		else stop_with("result beat appeared with no result outstanding");

	a_row: assert property (@(negedge clk) disable iff (reset)
		(out_valid && rd_idx < exp_count) |-> (out_beat.row == exp_q[rd_idx].row))
		else stop_with($sformatf("ERR %s row expected %0d actual %0d",
			exp_name[rd_idx], exp_q[rd_idx].row, out_beat.row));

	a_value: assert property (@(negedge clk) disable iff (reset)
		(out_valid && rd_idx < exp_count) |-> (out_beat.value == exp_q[rd_idx].value))
		else stop_with($sformatf("ERR %s value expected %0d actual %0d",
			exp_name[rd_idx], exp_q[rd_idx].value, out_beat.value));

	a_last: assert property (@(negedge clk) disable iff (reset)
		(out_valid && rd_idx < exp_count) |-> (out_beat.last == exp_q[rd_idx].last))
		else stop_with($sformatf("ERR %s last expected %0d actual %0d",
			exp_name[rd_idx], exp_q[rd_idx].last, out_beat.last));

	// beats never outrun the output credits
	a_out_credit: assert property (@(negedge clk) disable iff (reset)
		out_valid |-> (rd_idx < OUT_CREDITS + credits_back))
		else stop_with("result beat sent without an output credit");

	a_in_granted: assert property (@(negedge clk) disable iff (reset)
		in_credit |-> (credits_got - words_sent < IN_CREDITS))
		else stop_with("input credits granted beyond the skid queue depth");

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	initial begin
		rng      = 32'd97665;
		reset    = 1'b1;
		in_valid = 1'b0;
		in_beat  = '0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		// exactly one credit per queue entry before any word
		while (credits_got < IN_CREDITS)
			next_cycle();
		repeat (6) next_cycle();
		if (credits_got != IN_CREDITS)
			stop_with($sformatf("ERR reset credits expected %0d actual %0d",
				IN_CREDITS, credits_got));

		for (int n = 1; n <= NUM_PE; n++) begin	// one round
			send_job("single_round", n, draw(3), 1'b0);
			wait_drain();
		end

		for (int n = NUM_PE + 1; n <= MAX_N; n++) begin	// rows 4..7 too
			send_job("two_rounds", n, draw(2), 1'b0);
			wait_drain();
		end
		send_job("two_rounds_max", MAX_N, 0, 1'b1);	// 8 * 255 * 255
		wait_drain();

		for (int i = 0; i < 4; i++) begin
			hold_left = 40 + draw(40);	// long credit stall
			limit     = limit + hold_left;
			send_job("back_pressure", 1 + draw(MAX_N), 0, 1'b0);
		end
		wait_drain();

		for (int i = 0; i < 6; i++)	// back to back, no drain wait
			send_job("overlap", 1 + draw(MAX_N), 0, 1'b0);
		wait_drain();

		repeat (10) next_cycle();	// room for a stray beat
		// every queue entry handed back once all words moved on
		if (credits_got - words_sent != IN_CREDITS) begin
			stop_with($sformatf("ERR final_credits expected %0d actual %0d",
				IN_CREDITS, credits_got - words_sent));
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// File: hdl/mxv_top.sv
`timescale 1ns/1ps

module mxv_top
	import mxv_pkg::*;
#(
	parameter int IN_CREDITS  = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      in_valid,
	input  in_beat_t  in_beat,
	output logic      in_credit,
	output logic      out_valid,
	output res_beat_t out_beat,
	input  logic      out_credit
);

	logic               job_valid;
	job_t               job;
	logic               job_release;
	rd_req_t            rd_req;
	elem_t [NUM_PE-1:0] mat_elem;
	elem_t              vec_elem;
	logic               room;
	pe_ctrl_t           pe_ctrl;
	logic               pe_valid;
	logic               res_valid;
	res_beat_t          res;

	////////////////////////////////////////
	// load, compute, store
	////////////////////////////////////////
	mxv_load #(.IN_CREDITS(IN_CREDITS)) u_load (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_beat(in_beat), .in_credit(in_credit),
		.job_valid(job_valid), .job(job), .job_release(job_release),
		.rd_req(rd_req), .mat_elem(mat_elem), .vec_elem(vec_elem)
	);

	mxv_sequencer u_sequencer (
		.clk(clk), .reset(reset),
		.job_valid(job_valid), .job(job), .job_release(job_release),
		.rd_req(rd_req), .mat_elem(mat_elem), .vec_elem(vec_elem),
		.room(room), .pe_ctrl(pe_ctrl), .pe_valid(pe_valid)
	);

	mxv_pe_array u_pe_array (
		.clk(clk), .reset(reset),
		.pe_valid(pe_valid), .pe_ctrl(pe_ctrl),
		.res_valid(res_valid), .res(res)
	);

	mxv_result_store #(.OUT_CREDITS(OUT_CREDITS)) u_result_store (
		.clk(clk), .reset(reset),
		.res_valid(res_valid), .res(res), .room(room),
		.out_valid(out_valid), .out_beat(out_beat), .out_credit(out_credit)
	);

endmodule

// File: hdl/mxv_result_store.sv
`timescale 1ns/1ps

module mxv_result_store
	import mxv_pkg::*;
#(
	parameter int OUT_CREDITS = 2
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      res_valid,
	input  res_beat_t res,
	output logic      room,
	output logic      out_valid,
	output res_beat_t out_beat,
	input  logic      out_credit
);

	localparam int DEPTH = MAX_N;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRD_W = $clog2(OUT_CREDITS + 1);

	res_beat_t        q_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] q_count;
	logic [CRD_W-1:0] credits;	// beats the sink can still take
	logic             send;

	assign send = (q_count != '0) && (credits != '0);
	assign room = (int'(q_count) <= DEPTH - NUM_PE);	// a full round fits

	////////////////////////////////////////
	// result queue
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (res_valid)
			q_mem[wr_ptr] <= res;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			q_count <= '0;
		end else begin
			if (res_valid)
				wr_ptr <= wr_ptr + 1'b1;	// depth is a power of two
			if (send)
				rd_ptr <= rd_ptr + 1'b1;
			q_count <= q_count + CNT_W'(res_valid) - CNT_W'(send);
		end
	end

	////////////////////////////////////////
	// output credits
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			credits   <= CRD_W'(OUT_CREDITS);
			out_valid <= 1'b0;
		end else begin
			credits   <= credits + CRD_W'(out_credit) - CRD_W'(send);
			out_valid <= send;
		end
	end

	always_ff @(posedge clk) begin
		if (send)
			out_beat <= q_mem[rd_ptr];
	end

	// sink hands back no more than it was given
	a_credit_max: assert property (@(posedge clk) disable iff (reset)
		int'(credits) <= OUT_CREDITS);

	// sequencer room check keeps the queue from filling
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> (int'(q_count) < DEPTH));

endmodule

// File: hdl/mxv_pe_array.sv
`timescale 1ns/1ps

module mxv_pe_array
	import mxv_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      pe_valid,
	input  pe_ctrl_t  pe_ctrl,
	output logic      res_valid,
	output res_beat_t res
);

	localparam int PROD_W = 2 * ELEM_W;

	elem_t [NUM_PE-1:0] vec_op;	// vector element seen by each PE
	elem_t [NUM_PE-2:0] vec_q;	// shift chain between PEs
	logic [PROD_W-1:0]  prod [NUM_PE];
	acc_t               acc [NUM_PE];
	acc_t               acc_next [NUM_PE];
	logic [NUM_PE-1:0]  emit;	// row finished this cycle

	////////////////////////////////////////
	// vector shift chain
	////////////////////////////////////////
	always_comb begin
		vec_op[0] = pe_ctrl.vec_valid ? pe_ctrl.vec : '0;	// zeros trail the vector
		for (int k = 1; k < NUM_PE; k++)
			vec_op[k] = vec_q[k-1];
	end

	// moves only with operands so the skew holds across stalls
	always_ff @(posedge clk) begin
		if (pe_valid) begin
			for (int k = 0; k < NUM_PE - 1; k++)
				vec_q[k] <= vec_op[k];
		end
	end

	////////////////////////////////////////
	// multiply accumulate
	////////////////////////////////////////
	always_comb begin
		for (int k = 0; k < NUM_PE; k++) begin
			prod[k]     = PROD_W'(pe_ctrl.mat[k]) * PROD_W'(vec_op[k]);
			acc_next[k] = pe_ctrl.first[k] ? ACC_W'(prod[k])	// restart the row
				: acc[k] + ACC_W'(prod[k]);
			emit[k]     = pe_valid && pe_ctrl.last[k] && pe_ctrl.active[k];
		end
	end

	always_ff @(posedge clk) begin
		if (pe_valid) begin
			for (int k = 0; k < NUM_PE; k++)
				acc[k] <= acc_next[k];
		end
	end

	////////////////////////////////////////
	// result out
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset)
			res_valid <= 1'b0;
		else
			res_valid <= |emit;
	end

	// skewed lasts, so at most one PE writes here
	always_ff @(posedge clk) begin
		for (int k = 0; k < NUM_PE; k++) begin
			if (emit[k]) begin
				res.row   <= pe_ctrl.row[k];
				res.value <= acc_next[k];	// includes the last term
				res.last  <= pe_ctrl.tail[k];
			end
		end
	end

	// the sequencer skew keeps row completions one per cycle
	a_one_emit: assert property (@(posedge clk) disable iff (reset)
		$onehot0(emit));

endmodule

// File: hdl/mxv_sequencer.sv
`timescale 1ns/1ps

module mxv_sequencer
	import mxv_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic               job_valid,
	input  job_t               job,
	output logic               job_release,
	output rd_req_t            rd_req,
	input  elem_t [NUM_PE-1:0] mat_elem,
	input  elem_t              vec_elem,
	input  logic               room,
	output pe_ctrl_t           pe_ctrl,
	output logic               pe_valid
);

	localparam int DRAIN = 2;	// cycles until the last result sits in the store

	typedef enum logic [1:0] {S_IDLE, S_ROUND, S_DONE} state_t;

	state_t             state;
	logic [N_W-1:0]     step;	// round step, drain count in done
	logic               rnd;	// second round covers rows 4..7
	logic [ROW_W-1:0]   base;
	logic               last_round;
	logic               round_end;
	logic               drained;
	logic               vec_live;	// step still inside the vector
	logic [ROW_W-1:0]   col;
	elem_t [NUM_PE-1:0] hist [NUM_PE-1];	// older column reads, newest first
	elem_t [NUM_PE-1:0] skew_mat;

	assign base       = rnd ? ROW_W'(NUM_PE) : '0;
	assign last_round = rnd || (job.n <= N_W'(NUM_PE));
	assign round_end  = (step == job.n + N_W'(NUM_PE - 2));	// n + 3 steps
	assign drained    = (step == N_W'(DRAIN));
	assign vec_live   = (state == S_ROUND) && (step < job.n);
	assign col        = vec_live ? step[ROW_W-1:0] : '0;

	assign rd_req.mat_idx = {base, col};
	assign rd_req.vec_idx = col;
	assign job_release    = (state == S_DONE) && drained && last_round;

	////////////////////////////////////////
	// round control
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			step  <= '0;
			rnd   <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (job_valid && room) begin
					state <= S_ROUND;
					step  <= '0;
					rnd   <= 1'b0;
				end
				S_ROUND: if (round_end) begin
					state <= S_DONE;
					step  <= '0;
				end else begin
					step <= step + 1'b1;
				end
				S_DONE: if (!drained) begin
					step <= step + 1'b1;	// let the store count settle
				end else if (last_round) begin
					state <= S_IDLE;
				end else if (room) begin
					state <= S_ROUND;
					step  <= '0;
					rnd   <= 1'b1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// operand skew
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		hist[0] <= mat_elem;
		for (int i = 1; i < NUM_PE - 1; i++)
			hist[i] <= hist[i-1];
	end

	// element k takes the column read k cycles ago
	always_comb begin
		skew_mat[0] = mat_elem[0];
		for (int k = 1; k < NUM_PE; k++)
			skew_mat[k] = hist[k-1][k];
	end

	always_ff @(posedge clk) begin
		if (reset)
			pe_valid <= 1'b0;
		else
			pe_valid <= (state == S_ROUND);
	end

	always_ff @(posedge clk) begin
		pe_ctrl.vec_valid <= vec_live;
		pe_ctrl.vec       <= vec_elem;
		for (int k = 0; k < NUM_PE; k++) begin
			// zero outside the row's window of n terms
			pe_ctrl.mat[k]    <= (int'(step) >= k && int'(step) < k + int'(job.n)) ?
				skew_mat[k] : '0;
			pe_ctrl.first[k]  <= (int'(step) == k);
			pe_ctrl.last[k]   <= (int'(step) == k + int'(job.n) - 1);
			pe_ctrl.row[k]    <= base + ROW_W'(k);
			pe_ctrl.active[k] <= (int'(base) + k < int'(job.n));
			pe_ctrl.tail[k]   <= (int'(base) + k == int'(job.n) - 1);
		end
	end

	// operands reach the array a cycle after the round begins
	a_room_at_start: assert property (@(posedge clk) disable iff (reset)
		$rose(pe_valid) |-> $past(room, 2));

endmodule

// File: hdl/mxv_load.sv
`timescale 1ns/1ps

module mxv_load
	import mxv_pkg::*;
#(
	parameter int IN_CREDITS = 4
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               in_valid,
	input  in_beat_t           in_beat,
	output logic               in_credit,
	output logic               job_valid,
	output job_t               job,
	input  logic               job_release,
	input  rd_req_t            rd_req,
	output elem_t [NUM_PE-1:0] mat_elem,
	output elem_t              vec_elem
);

	localparam int PTR_W = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
	localparam int CNT_W = $clog2(IN_CREDITS + 1);

	in_beat_t         q_mem [IN_CREDITS];	// skid queue
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] q_count;
	logic [CNT_W-1:0] owed;	// credits still to hand back
	logic             move;	// head word goes to the buffers
	in_word_u         head;

	elem_t            mat_mem [MAX_N*MAX_N];	// row stride of 8
	elem_t            vec_mem [MAX_N];
	logic             armed;	// header seen, job still filling
	logic             in_vec;	// matrix done, vector words next
	logic [ROW_W-1:0] m_row;
	logic [ROW_W-1:0] m_col;
	logic [ROW_W-1:0] v_idx;

	assign move = (q_count != '0) && !job_valid;	// hold off while a job waits
	assign head = q_mem[rd_ptr].word;

	////////////////////////////////////////
	// skid queue and credit return
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (in_valid)
			q_mem[wr_ptr] <= in_beat;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			q_count <= '0;
		end else begin
			if (in_valid)
				wr_ptr <= (wr_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (move)
				rd_ptr <= (rd_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			q_count <= q_count + CNT_W'(in_valid) - CNT_W'(move);
		end
	end

	// one pulse per owed credit, the whole queue is owed after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			owed      <= CNT_W'(IN_CREDITS);
			in_credit <= 1'b0;
		end else begin
			in_credit <= (owed != '0);
			owed      <= owed - CNT_W'(owed != '0) + CNT_W'(move);
		end
	end

	////////////////////////////////////////
	// word decode and buffer fill
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			armed     <= 1'b0;
			in_vec    <= 1'b0;
			job_valid <= 1'b0;
			job       <= '0;
			m_row     <= '0;
			m_col     <= '0;
			v_idx     <= '0;
		end else begin
			if (job_release)
				job_valid <= 1'b0;	// sequencer is finished with the buffers
			if (move) begin
				if (head.hdr.kind) begin	// new job, restart counters
					job.n  <= head.hdr.n;
					armed  <= 1'b1;
					in_vec <= 1'b0;
					m_row  <= '0;
					m_col  <= '0;
					v_idx  <= '0;
				end else if (armed && !in_vec) begin
					if ({1'b0, m_col} == job.n - 1'b1) begin	// end of a matrix row
						m_col <= '0;
						m_row <= m_row + 1'b1;
						if ({1'b0, m_row} == job.n - 1'b1)
							in_vec <= 1'b1;
					end else begin
						m_col <= m_col + 1'b1;
					end
				end else if (armed) begin
					v_idx <= v_idx + 1'b1;
					if ({1'b0, v_idx} == job.n - 1'b1) begin	// last vector word
						armed     <= 1'b0;
						job_valid <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (move && !head.data.kind && armed) begin
			if (!in_vec)
				mat_mem[{m_row, m_col}] <= head.data.elem;
			else
				vec_mem[v_idx] <= head.data.elem;
		end
	end

	// one column of four rows per read
	always_comb begin
		for (int k = 0; k < NUM_PE; k++) begin
			mat_elem[k] = mat_mem[{rd_req.mat_idx[2*ROW_W-1:ROW_W] + ROW_W'(k),
				rd_req.mat_idx[ROW_W-1:0]}];
		end
	end

	assign vec_elem = vec_mem[rd_req.vec_idx];

	////////////////////////////////////////
	// checks
	////////////////////////////////////////
	// queued + owed + pulsing leaves at least one credit with the source
	a_credit_held: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> (int'(q_count) + int'(owed) + int'(in_credit) < IN_CREDITS));

	a_hdr_size: assert property (@(posedge clk) disable iff (reset)
		(move && head.hdr.kind) |-> (head.hdr.n >= 1 && head.hdr.n <= MAX_N));

endmodule

// File: hdl/mxv_pkg.sv
package mxv_pkg;

	////////////////////////////////////////
	// sizes
	////////////////////////////////////////
	localparam int MAX_N  = 8;	// largest matrix size
	localparam int NUM_PE = 4;	// processing elements per round
	localparam int ELEM_W = 8;
	localparam int ACC_W  = 20;	// 8 * 255 * 255 fits in 20 bits
	localparam int N_W    = 4;	// holds 1..8
	localparam int ROW_W  = 3;	// row or column index

	typedef logic [ELEM_W-1:0] elem_t;
	typedef logic [ACC_W-1:0]  acc_t;

	////////////////////////////////////////
	// input word, two views of 9 bits
	////////////////////////////////////////
	typedef struct packed {
		logic                  kind;	// 1 for a header
		logic [ELEM_W-N_W-1:0] rsvd;
		logic [N_W-1:0]        n;	// matrix size
	} hdr_t;

	typedef struct packed {
		logic  kind;	// 0 for a data word
		elem_t elem;
	} data_t;

	typedef union packed {
		hdr_t  hdr;
		data_t data;
	} in_word_u;

	typedef struct packed {
		in_word_u word;
	} in_beat_t;

	// loaded job, load stage to sequencer
	typedef struct packed {
		logic [N_W-1:0] n;
	} job_t;

	// buffer read addresses from the sequencer
	typedef struct packed {
		logic [2*ROW_W-1:0] mat_idx;	// {row base, column}
		logic [ROW_W-1:0]   vec_idx;
	} rd_req_t;

	// one cycle of operands for the array
	typedef struct packed {
		logic                           vec_valid;
		elem_t                          vec;	// enters element 0
		elem_t [NUM_PE-1:0]             mat;	// already skewed
		logic [NUM_PE-1:0]              first;
		logic [NUM_PE-1:0]              last;
		logic [NUM_PE-1:0]              tail;	// row is n-1
		logic [NUM_PE-1:0]              active;	// row below n
		logic [NUM_PE-1:0][ROW_W-1:0]   row;
	} pe_ctrl_t;

	typedef struct packed {
		logic [ROW_W-1:0] row;
		acc_t             value;
		logic             last;	// row n-1 of the job
	} res_beat_t;

endpackage
